//--- Bender.yml
package:
  name: h264_bitstream

sources:
  - files:
      - design/h264_bits_pkg.sv
      - design/slice_header_writer.sv
      - design/coef_block_coder.sv
      - design/vlc_arbiter.sv
      - design/bit_packer.sv
      - design/h264_bitstream_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_h264_bitstream.sv

//--- bench/tb_bit_model.svh
`ifndef TB_BIT_MODEL_SVH
`define TB_BIT_MODEL_SVH

bit exp_bits[$];
int sig_bits;      // Coded bits of the running slice without pad.
int exp_bytes;     // Whole bytes expected so far.

task automatic push_bits(input longint val, input int len);
	for (int i = len - 1; i >= 0; i--)
	begin
		exp_bits.push_back(val[i]);
	end
	sig_bits += len;
endtask

// Exp-Golomb: n leading zeros, then v+1 in n+1 bits.
task automatic push_ue(input longint v);
	longint w;
	int     n;
	w = v + 1;
	n = 0;
	while ((w >> (n + 1)) != 0)
	begin
		n++;
	end
	push_bits(w, 2 * n + 1);
endtask

task automatic push_se(input int k);
	if (k > 0)
	begin
		push_ue(2 * k - 1);
	end
	else
	begin
		push_ue(-2 * k);
	end
endtask

task automatic push_header(input int q);
	push_ue(0);
	push_ue(7);
	push_se(q - 26);
endtask

task automatic push_block(input int vals[16]);
	int nz;
	int run;
	nz  = 0;
	run = 0;
	foreach (vals[i])
	begin
		if (vals[i] != 0)
		begin
			nz++;
		end
	end
	push_ue(nz);
	foreach (vals[i])
	begin
		if (vals[i] == 0)
		begin
			run++;
		end
		else
		begin
			push_ue(run);
			push_se(vals[i]);
			run = 0;
		end
	end
endtask

// Stop bit, then zeros up to the byte boundary.
task automatic push_trailer();
	push_bits(1, 1);
	exp_bytes += (sig_bits + 7) / 8;     // Each slice padded on its own.
	sig_bits = 0;
	while (exp_bits.size() % 8 != 0)
	begin
		exp_bits.push_back(1'b0);
	end
endtask

`endif

//--- bench/tb_h264_bitstream.sv
`default_nettype none
`timescale 1ns/10ps

module tb_h264_bitstream;
	import h264_bits_pkg::*;

	logic                     clk2;
	logic                     rst_n;
	logic                     new_slice;
	logic [5:0]               qp;
	logic                     slice_end;
	logic                     coef_valid;
	logic signed [coef_w-1:0] coef;
	logic                     coef_ready;
	logic                     blk_done;
	logic [7:0]               byte_out;
	logic                     byte_strobe;
	logic                     slice_done;

	string      test_name;
	int         error_count;
	int         byte_count;
	int         stall_cycles;
	int         seed;
	logic [7:0] exp_byte;

	`include "tb_bit_model.svh"

	h264_bitstream_top uut
	(
		.clk2        ( clk2        ),
		.rst_n       ( rst_n       ),
		.new_slice   ( new_slice   ),
		.qp          ( qp          ),
		.slice_end   ( slice_end   ),
		.coef_valid  ( coef_valid  ),
		.coef        ( coef        ),
		.coef_ready  ( coef_ready  ),
		.blk_done    ( blk_done    ),
		.byte_out    ( byte_out    ),
		.byte_strobe ( byte_strobe ),
		.slice_done  ( slice_done  )
	);

	always #5 clk2 = ~clk2;

	task automatic check_equal(input string item, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
				test_name, item, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value check");
		end
	endtask

	// Each output byte against the next 8 model bits.
	always @(negedge clk2)
	begin
		if (rst_n && byte_strobe)
		begin
			if (exp_bits.size() < 8)
			begin
				error_count++;
				$display("byte 0x%0h came out with no expected bits left in %s",
					byte_out, test_name);
				$display("Simulation failed");
				$fatal(1, "extra byte");
			end
			else
			begin
				exp_byte = 8'h00;
				for (int i = 0; i < 8; i++)
				begin
					exp_byte = {exp_byte[6:0], exp_bits.pop_front()};
				end
				byte_count++;
				check_equal("byte_out", exp_byte, byte_out);
			end
		end
		if (rst_n && !uut.pk_ready)
		begin
			stall_cycles++;
		end
	end

	task automatic wait_for(input string sig_name, input int limit);
		int   n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit)
		begin
			@(negedge clk2);
			if (sig_name == "coef_ready")
			begin
				seen = coef_ready;
			end
			else if (sig_name == "blk_done")
			begin
				seen = blk_done;
			end
			else
			begin
				seen = slice_done;
			end
			n++;
		end
		if (!seen)
		begin
			error_count++;
			$display("timeout: %s never came in %s", sig_name, test_name);
			$display("Simulation failed");
			$fatal(1, "wait timeout");
		end
	endtask

	task automatic begin_test(input string name);
		test_name    = name;
		sig_bits     = 0;
		exp_bytes    = 0;
		byte_count   = 0;
		stall_cycles = 0;
	endtask

	task automatic finish_test();
		check_equal("bits left over", 0, exp_bits.size());
		check_equal("byte count", exp_bytes, byte_count);
	endtask

	task automatic start_slice(input int q);
		push_header(q);
		@(posedge clk2);
		new_slice <= 1'b1;
		qp        <= 6'(q);
		@(posedge clk2);
		new_slice <= 1'b0;
	endtask

	task automatic end_slice();
		push_trailer();
		@(posedge clk2);
		slice_end <= 1'b1;
		@(posedge clk2);
		slice_end <= 1'b0;
		wait_for("slice_done", 200);
	endtask

	// With end_now the slice ends while the block is still being coded.
	task automatic send_block(input int vals[16], input logic end_now);
		push_block(vals);
		wait_for("coef_ready", 200);
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk2);
			coef_valid <= 1'b1;
			coef       <= coef_w'(vals[i]);
		end
		@(posedge clk2);
		coef_valid <= 1'b0;
		if (end_now)
		begin
			push_trailer();
			slice_end <= 1'b1;
			@(posedge clk2);
			slice_end <= 1'b0;
		end
		wait_for("blk_done", 1000);
		check_equal("coef_ready with blk_done", 1, coef_ready);
	endtask

	task automatic test_header_only();
		int qps[3];
		qps = '{26, 0, 51};
		begin_test("header_only");
		check_equal("byte_strobe after reset", 0, byte_strobe);
		check_equal("slice_done after reset", 0, slice_done);
		check_equal("blk_done after reset", 0, blk_done);
		check_equal("hdr_req after reset", 0, uut.hdr_req);
		check_equal("coef_req after reset", 0, uut.coef_req);
		check_equal("coef_ready after reset", 1, coef_ready);
		foreach (qps[i])
		begin
			start_slice(qps[i]);
			end_slice();
		end
		finish_test();
	endtask

	task automatic test_zero_blocks();
		int blk[16];
		begin_test("zero_blocks");
		blk = '{default: 0};
		start_slice(30);
		send_block(blk, 1'b0);
		send_block(blk, 1'b0);
		end_slice();
		finish_test();
	endtask

	task automatic test_sparse_block();
		int blk[16];
		begin_test("sparse_block");
		blk     = '{default: 0};
		blk[0]  = 5;
		blk[5]  = -3;
		blk[15] = 1;
		start_slice(20);
		send_block(blk, 1'b0);
		end_slice();
		finish_test();
	endtask

	task automatic test_random_blocks();
		int blk[16];
		int r;
		begin_test("random_blocks");
		start_slice(40);
		for (int b = 0; b < 10; b++)
		begin
			foreach (blk[i])
			begin
				r = $random(seed);
				case (r & 7)
					0:       blk[i] = 2047;
					1:       blk[i] = -2047;
					2:       blk[i] = -2048;     // Longest code, 25 bits.
					3, 4:    blk[i] = r >>> 21;
					default: blk[i] = 0;
				endcase
			end
			send_block(blk, 1'b0);
		end
		check_equal("pk_ready stalls seen", 1, stall_cycles > 0);
		end_slice();
		finish_test();
	endtask

	task automatic test_deferred_end();
		int blk[16];
		begin_test("deferred_end");
		foreach (blk[i])
		begin
			blk[i] = (i % 3 == 0) ? (i - 7) * 90 : 0;
		end
		start_slice(33);
		send_block(blk, 1'b1);
		wait_for("slice_done", 200);
		finish_test();
	endtask

	initial
	begin
		seed        = 32'h6e9a_63a1;
		error_count = 0;
		test_name   = "reset";
		clk2        = 1'b0;
		rst_n       = 1'b0;
		new_slice   = 1'b0;
		qp          = 6'd0;
		slice_end   = 1'b0;
		coef_valid  = 1'b0;
		coef        = '0;
		repeat (2) @(posedge clk2);
		rst_n <= 1'b1;
		@(negedge clk2);
		test_header_only();
		test_zero_blocks();
		test_sparse_block();
		test_random_blocks();
		test_deferred_end();
		if (error_count == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/bit_packer.sv
`default_nettype none
`timescale 1ns/10ps

module bit_packer
(
	input  logic                clk2,
	input  logic                rst_n,
	input  logic                pk_valid,
	input  h264_bits_pkg::vlc_t pk_code,
	output logic                pk_ready,
	output logic [7:0]          byte_out,
	output logic                byte_strobe,
	output logic                slice_done
);
	import h264_bits_pkg::*;

	logic [acc_w-1:0] acc;
	logic [acc_w-1:0] keep_mask;
	logic [acc_w-1:0] new_bits;
	logic [5:0]       cnt;
	logic [5:0]       sum_len;
	logic [5:0]       pad_len;
	logic             pad_busy;
	logic             accept;
	logic             last_byte;

	assign pk_ready    = (cnt < 6'd8) && !pad_busy;
	assign accept      = pk_valid && pk_ready;
	assign byte_strobe = (cnt >= 6'd8);
	assign byte_out    = acc[acc_w-1 -: 8];
	assign last_byte   = byte_strobe && pad_busy && (cnt == 6'd8);

	// New code lands right below the pending bits.
	assign keep_mask = ~({acc_w{1'b1}} >> cnt);
	assign new_bits  = ({pk_code.ve, {(acc_w - code_w){1'b0}}} << (code_w - pk_code.vl)) >> cnt;
	assign sum_len   = cnt + 6'(pk_code.vl);
	assign pad_len   = (sum_len + 6'd7) & 6'b11_1000;     // Round up to whole bytes.

	always_ff @(posedge clk2)
	begin
		if (accept)
		begin
			acc <= (acc & keep_mask) | new_bits;
		end
		else if (byte_strobe)
		begin
			acc <= acc << 8;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (!rst_n)
		begin
			cnt        <= 6'd0;
			pad_busy   <= 1'b0;
			slice_done <= 1'b0;
		end
		else
		begin
			slice_done <= last_byte;
			if (accept)
			begin
				cnt      <= pk_code.pad ? pad_len : sum_len;
				pad_busy <= pk_code.pad;
			end
			else if (byte_strobe)
			begin
				cnt <= cnt - 6'd8;
				if (last_byte)
				begin
					pad_busy <= 1'b0;
				end
			end
		end
	end

	a_cnt_bound: assert property (@(posedge clk2) disable iff (!rst_n)
		cnt <= 6'(acc_w));

endmodule

`default_nettype wire

//--- design/coef_block_coder.sv
`default_nettype none
`timescale 1ns/10ps

module coef_block_coder
(
	input  logic                                    clk2,
	input  logic                                    rst_n,
	input  logic                                    coef_valid,
	input  logic signed [h264_bits_pkg::coef_w-1:0] coef,
	input  logic                                    coef_gnt,
	output logic                                    coef_ready,
	output logic                                    blk_done,
	output logic                                    coef_req,
	output h264_bits_pkg::vlc_t                     coef_code
);
	import h264_bits_pkg::*;

	logic [1:0]               phase;
	logic [3:0]               wr_cnt;
	logic [4:0]               nz_cnt;
	logic [3:0]               zrun;
	logic [3:0]               rd_ptr;
	logic                     wr_en;
	logic                     wr_nz;
	logic                     wr_last;
	logic                     last_nz;
	logic signed [coef_w-1:0] lvl_buf [blk_coefs];
	logic [3:0]               run_buf [blk_coefs];

	assign coef_ready = (phase == cb_load);
	assign coef_req   = (phase != cb_load);
	assign wr_en      = coef_valid && coef_ready;
	assign wr_nz      = wr_en && (coef != '0);
	assign wr_last    = wr_en && (wr_cnt == 4'(blk_coefs - 1));
	assign last_nz    = ({1'b0, rd_ptr} == nz_cnt - 5'd1);

	// Nonzero levels stored packed, each with its preceding zero run.
	always_ff @(posedge clk2)
	begin
		if (wr_nz)
		begin
			lvl_buf[nz_cnt[3:0]] <= coef;
			run_buf[nz_cnt[3:0]] <= zrun;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (!rst_n)
		begin
			phase    <= cb_load;
			wr_cnt   <= 4'd0;
			nz_cnt   <= 5'd0;
			zrun     <= 4'd0;
			rd_ptr   <= 4'd0;
			blk_done <= 1'b0;
		end
		else
		begin
			blk_done <= 1'b0;
			case (phase)
				cb_load:
				begin
					if (wr_en)
					begin
						wr_cnt <= wr_cnt + 4'd1;
						if (wr_nz)
						begin
							nz_cnt <= nz_cnt + 5'd1;
							zrun   <= 4'd0;
						end
						else
						begin
							zrun <= zrun + 4'd1;
						end
						if (wr_last)
						begin
							zrun  <= 4'd0;     // Trailing zeros dropped.
							phase <= cb_count;
						end
					end
				end
				cb_count:
				begin
					if (coef_gnt)
					begin
						rd_ptr <= 4'd0;
						if (nz_cnt == 5'd0)
						begin
							blk_done <= 1'b1;
							phase    <= cb_load;
						end
						else
						begin
							phase <= cb_run;
						end
					end
				end
				cb_run:
				begin
					if (coef_gnt)
					begin
						phase <= cb_level;
					end
				end
				default:
				begin
					if (coef_gnt)
					begin
						if (last_nz)
						begin
							blk_done <= 1'b1;
							nz_cnt   <= 5'd0;
							phase    <= cb_load;
						end
						else
						begin
							rd_ptr <= rd_ptr + 4'd1;
							phase  <= cb_run;
						end
					end
				end
			endcase
		end
	end

	always_comb
	begin
		case (phase)
			cb_count: coef_code = ue_code(code_w'(nz_cnt));
			cb_run:   coef_code = ue_code(code_w'(run_buf[rd_ptr]));
			cb_level: coef_code = se_code(lvl_buf[rd_ptr]);
			default:  coef_code = '0;
		endcase
	end

	a_no_overrun: assert property (@(posedge clk2) disable iff (!rst_n)
		coef_valid |-> coef_ready);

endmodule

`default_nettype wire

//--- design/h264_bits_pkg.sv
`default_nettype none

package h264_bits_pkg;

	localparam int code_w    = 25;     // Longest code, level of -2048.
	localparam int len_w     = 5;
	localparam int coef_w    = 12;
	localparam int blk_coefs = 16;
	localparam int acc_w     = 32;     // Packer accumulator.

	localparam logic [1:0] cb_load  = 2'd0;
	localparam logic [1:0] cb_count = 2'd1;
	localparam logic [1:0] cb_run   = 2'd2;
	localparam logic [1:0] cb_level = 2'd3;

	typedef struct packed {
		logic [code_w-1:0] ve;     // Right-aligned code bits.
		logic [len_w-1:0]  vl;
		logic              pad;    // Zero fill to byte after this code.
	} vlc_t;

	localparam vlc_t trail_code = '{ve: code_w'(1), vl: len_w'(1), pad: 1'b1};

	function automatic vlc_t ue_code(input logic [code_w-1:0] v);
		logic [code_w-1:0] v1;
		int                n;
		vlc_t              c;
		v1 = v + 1'b1;
		n  = 0;
		for (int i = 0; i < code_w; i++)
		begin
			if (v1[i])
			begin
				n = i;     // Highest set bit of v+1.
			end
		end
		c.ve  = v1;
		c.vl  = len_w'(2 * n + 1);
		c.pad = 1'b0;
		return c;
	endfunction

	function automatic vlc_t se_code(input logic signed [coef_w-1:0] k);
		logic signed [code_w-1:0] kx;
		logic [code_w-1:0]        m;
		kx = k;
		if (kx > 0)
		begin
			m = (kx <<< 1) - 1;
		end
		else
		begin
			m = -(kx <<< 1);
		end
		return ue_code(m);
	endfunction

endpackage

`default_nettype wire

//--- design/h264_bitstream_top.sv
`default_nettype none
`timescale 1ns/10ps

module h264_bitstream_top
(
	input  logic                                    clk2,
	input  logic                                    rst_n,
	input  logic                                    new_slice,
	input  logic [5:0]                              qp,
	input  logic                                    slice_end,
	input  logic                                    coef_valid,
	input  logic signed [h264_bits_pkg::coef_w-1:0] coef,
	output logic                                    coef_ready,
	output logic                                    blk_done,
	output logic [7:0]                              byte_out,
	output logic                                    byte_strobe,
	output logic                                    slice_done
);
	import h264_bits_pkg::*;

	logic hdr_req;
	logic hdr_gnt;
	logic coef_req;
	logic coef_gnt;
	logic pk_valid;
	logic pk_ready;
	vlc_t hdr_code;
	vlc_t coef_code;
	vlc_t pk_code;

	slice_header_writer ins_header
	(
		.clk2      ( clk2      ),
		.rst_n     ( rst_n     ),
		.new_slice ( new_slice ),
		.qp        ( qp        ),
		.hdr_gnt   ( hdr_gnt   ),
		.hdr_req   ( hdr_req   ),
		.hdr_code  ( hdr_code  )
	);

	coef_block_coder ins_coder
	(
		.clk2       ( clk2       ),
		.rst_n      ( rst_n      ),
		.coef_valid ( coef_valid ),
		.coef       ( coef       ),
		.coef_gnt   ( coef_gnt   ),
		.coef_ready ( coef_ready ),
		.blk_done   ( blk_done   ),
		.coef_req   ( coef_req   ),
		.coef_code  ( coef_code  )
	);

	vlc_arbiter ins_arbiter
	(
		.clk2      ( clk2      ),
		.rst_n     ( rst_n     ),
		.slice_end ( slice_end ),
		.hdr_req   ( hdr_req   ),
		.hdr_code  ( hdr_code  ),
		.coef_req  ( coef_req  ),
		.coef_code ( coef_code ),
		.pk_ready  ( pk_ready  ),
		.hdr_gnt   ( hdr_gnt   ),
		.coef_gnt  ( coef_gnt  ),
		.pk_valid  ( pk_valid  ),
		.pk_code   ( pk_code   )
	);

	bit_packer ins_packer
	(
		.clk2        ( clk2        ),
		.rst_n       ( rst_n       ),
		.pk_valid    ( pk_valid    ),
		.pk_code     ( pk_code     ),
		.pk_ready    ( pk_ready    ),
		.byte_out    ( byte_out    ),
		.byte_strobe ( byte_strobe ),
		.slice_done  ( slice_done  )
	);

endmodule

`default_nettype wire

//--- design/slice_header_writer.sv
`default_nettype none
`timescale 1ns/10ps

module slice_header_writer
(
	input  logic                clk2,
	input  logic                rst_n,
	input  logic                new_slice,
	input  logic [5:0]          qp,
	input  logic                hdr_gnt,
	output logic                hdr_req,
	output h264_bits_pkg::vlc_t hdr_code
);
	import h264_bits_pkg::*;

	logic [5:0]               qp_q;
	logic [1:0]               idx;
	logic signed [coef_w-1:0] qp_delta;

	assign qp_delta = coef_w'(qp_q) - coef_w'(26);

	always_ff @(posedge clk2)
	begin
		if (new_slice)
		begin
			qp_q <= qp;
		end
	end

	always_ff @(posedge clk2)
	begin
		if (!rst_n)
		begin
			hdr_req <= 1'b0;
			idx     <= 2'd0;
		end
		else if (new_slice)
		begin
			hdr_req <= 1'b1;
			idx     <= 2'd0;
		end
		else if (hdr_gnt)
		begin
			if (idx == 2'd2)
			begin
				hdr_req <= 1'b0;     // Third code taken.
			end
			idx <= idx + 2'd1;
		end
	end

	always_comb
	begin
		case (idx)
			2'd0:    hdr_code = ue_code(code_w'(0));     // first_mb_in_slice.
			2'd1:    hdr_code = ue_code(code_w'(7));     // I slice.
			default: hdr_code = se_code(qp_delta);       // slice_qp_delta.
		endcase
	end

	a_gnt_needs_req: assert property (@(posedge clk2) disable iff (!rst_n)
		hdr_gnt |-> hdr_req);

endmodule

`default_nettype wire

//--- design/vlc_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module vlc_arbiter
(
	input  logic                clk2,
	input  logic                rst_n,
	input  logic                slice_end,
	input  logic                hdr_req,
	input  h264_bits_pkg::vlc_t hdr_code,
	input  logic                coef_req,
	input  h264_bits_pkg::vlc_t coef_code,
	input  logic                pk_ready,
	output logic                hdr_gnt,
	output logic                coef_gnt,
	output logic                pk_valid,
	output h264_bits_pkg::vlc_t pk_code
);
	import h264_bits_pkg::*;

	logic trl_pend;
	logic trl_gnt;

	assign hdr_gnt  = pk_ready && hdr_req;
	assign coef_gnt = pk_ready && coef_req && !hdr_req;
	assign trl_gnt  = pk_ready && trl_pend && !hdr_req && !coef_req;
	assign pk_valid = hdr_gnt || coef_gnt || trl_gnt;

	always_comb
	begin
		if (hdr_req)
		begin
			pk_code = hdr_code;
		end
		else if (coef_req)
		begin
			pk_code = coef_code;
		end
		else
		begin
			pk_code = trail_code;     // Stop bit, then byte align.
		end
	end

	always_ff @(posedge clk2)
	begin
		if (!rst_n)
		begin
			trl_pend <= 1'b0;
		end
		else if (slice_end)
		begin
			trl_pend <= 1'b1;
		end
		else if (trl_gnt)
		begin
			trl_pend <= 1'b0;
		end
	end

	a_code_len: assert property (@(posedge clk2) disable iff (!rst_n)
		pk_valid |-> (pk_code.vl != '0) && (pk_code.vl <= len_w'(code_w)));

	a_hdr_held: assert property (@(posedge clk2) disable iff (!rst_n)
		(hdr_req && !hdr_gnt) |=> (hdr_req && $stable(hdr_code)));

	a_coef_held: assert property (@(posedge clk2) disable iff (!rst_n)
		(coef_req && !coef_gnt) |=> (coef_req && $stable(coef_code)));

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
design/h264_bits_pkg.sv
design/slice_header_writer.sv
design/coef_block_coder.sv
design/vlc_arbiter.sv
design/bit_packer.sv
design/h264_bitstream_top.sv
bench/tb_h264_bitstream.sv
